//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_top
FILELIST  = tb.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- branch_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// valid_i, cnd_i, tst_i, a_i and b_i all belong to one cycle
// taken_o one cycle after valid_i, no back-pressure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  logic                       valid_i,  // branch strobe
	input  logic                       cnd_i,    // 1 = conditional
	input  logic [tst_pkg::TST_W-1:0]  tst_i,
	input  logic [tst_pkg::DATA_W-1:0] a_i,
	input  logic [tst_pkg::DATA_W-1:0] b_i,
	output logic                       taken_o,
	output logic                       flush_o
);

	import tst_pkg::*;

	logic flg_nz;
	logic flg_lz;
	logic flg_ne;
	logic flg_lt;
	logic br_true;   // decoder result, one cycle late
	logic br_valid;  // valid_i lined up with br_true
	logic load;
	logic done;

	flg_gen u_flg (
		.a_i      (a_i),
		.b_i      (b_i),
		.tst_i    (tst_i),
		.flg_nz_o (flg_nz),
		.flg_lz_o (flg_lz),
		.flg_ne_o (flg_ne),
		.flg_lt_o (flg_lt)
	);

	// flags and code meet unregistered, result gets one stage
	tst_decode #(.REGS_TST(0), .REGS_OUT(1)) u_dec (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.flg_nz_i (flg_nz),
		.flg_lz_i (flg_lz),
		.flg_ne_i (flg_ne),
		.flg_lt_i (flg_lt),
		.cnd_i    (cnd_i),
		.tst_i    (tst_i),
		.result_o (br_true)
	);

	// matches REGS_OUT above
	pipe #(.DEPTH(1), .data_t(logic), .RESET_VAL(1'b0)) u_vld_dly (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.data_i  (valid_i),
		.data_o  (br_valid)
	);

	flush_ctl u_ctl (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.br_valid_i (br_valid),
		.br_true_i  (br_true),
		.done_i     (done),
		.taken_o    (taken_o),
		.flush_o    (flush_o),
		.load_o     (load)
	);

	flush_timer u_tmr (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.load_i  (load),
		.cnt_i   (CNT_W'(FLUSH_CYC)),  // fixed window length
		.done_o  (done)
	);

endmodule

`default_nettype wire

//--- flg_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// purely combinational, flags settle in the cycle of a/b
// lt is signed only for the LS/NLS codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module flg_gen (
	input  logic [tst_pkg::DATA_W-1:0] a_i,
	input  logic [tst_pkg::DATA_W-1:0] b_i,
	input  logic [tst_pkg::TST_W-1:0]  tst_i,     // picks signed or unsigned lt
	output logic                       flg_nz_o,  // a != 0
	output logic                       flg_lz_o,  // a < 0
	output logic                       flg_ne_o,  // a != b
	output logic                       flg_lt_o   // a < b
);

	import tst_pkg::*;

	logic sgn_cmp;  // 1 = signed magnitude compare
	logic lt_s;
	logic lt_u;

	// only the signed tests want the signed compare
	assign sgn_cmp = (tst_i == TST_LS) || (tst_i == TST_NLS);

	assign lt_s = $signed(a_i) < $signed(b_i);
	assign lt_u = a_i < b_i;

	// sign bit is enough for lz
	assign flg_nz_o = |a_i;
	assign flg_lz_o = a_i[DATA_W-1];
	assign flg_ne_o = (a_i != b_i);

	// one lt flag serves both families of tests
	assign flg_lt_o = sgn_cmp ? lt_s : lt_u;

endmodule

`default_nettype wire

//--- flush_ctl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// taken_o and load_o are combinational from br_valid/br_true
// branches seen during FLUSH are dropped, never queued
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module flush_ctl (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic br_valid_i,  // aligned branch strobe
	input  logic br_true_i,   // decoder result
	input  logic done_i,      // timer end of window
	output logic taken_o,     // pulse per accepted branch
	output logic flush_o,     // level over the window
	output logic load_o       // start the timer
);

	typedef enum logic {
		IDLE,
		FLUSH
	} state_t;

	state_t state_q;
	state_t state_d;
	logic   accept;  // taken branch seen while idle

	assign accept = (state_q == IDLE) && br_valid_i && br_true_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE:  if (accept) state_d = FLUSH;
			FLUSH: if (done_i) state_d = IDLE;  // timer decides the length
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	assign taken_o = accept;
	assign load_o  = accept;  // same strobe arms the timer
	assign flush_o = (state_q == FLUSH);

	// the timer only runs inside the window
	a_done_in_flush: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		done_i |-> flush_o)
		else $error("timer done outside flush");

endmodule

`default_nettype wire

//--- flush_timer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load only when idle, a count of 0 never gives done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module flush_timer (
	input  logic                      clk_i,
	input  logic                      rst_n_i,
	input  logic                      load_i,  // take cnt_i
	input  logic [tst_pkg::CNT_W-1:0] cnt_i,
	output logic                      done_o   // last cycle of the count
);

	import tst_pkg::*;

	logic [CNT_W-1:0] cnt_q;  // 0 = idle

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cnt_q <= '0;
		end else if (load_i) begin
			cnt_q <= cnt_i;
		end else if (cnt_q != '0) begin
			cnt_q <= cnt_q - CNT_W'(1);  // one per cycle, stops at 0
		end
	end

	// high while count sits at 1, so loaded N gives N cycles up to done
	assign done_o = (cnt_q == CNT_W'(1));

	// controller must wait for done before the next load
	a_no_reload: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		load_i |-> (cnt_q == '0))
		else $error("flush timer reloaded while running");

endmodule

`default_nettype wire

//--- pipe.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DEPTH 0 is a plain wire, no clock involved
// payload must be a packed type
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module pipe #(
	parameter int DEPTH = 1,              // register stages
	parameter type data_t = logic,        // payload
	parameter data_t RESET_VAL = '0       // value held during reset
) (
	input  logic  clk_i,
	input  logic  rst_n_i,
	input  data_t data_i,
	output data_t data_o
);

	if (DEPTH == 0) begin : g_wire
		assign data_o = data_i;  // no delay
	end else begin : g_regs
		data_t stage_q [DEPTH];  // stage 0 nearest the input

		always_ff @(posedge clk_i or negedge rst_n_i) begin
			if (!rst_n_i) begin
				for (int i = 0; i < DEPTH; i++) begin
					stage_q[i] <= RESET_VAL;
				end
			end else begin
				stage_q[0] <= data_i;
				for (int i = 1; i < DEPTH; i++) begin
					stage_q[i] <= stage_q[i-1];  // shift along
				end
			end
		end

		assign data_o = stage_q[DEPTH-1];

		// a clean source upstream keeps the whole chain known
		a_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
			!$isunknown(data_o))
			else $error("pipe output unknown");
	end

endmodule

`default_nettype wire

//--- tb.f
tst_pkg.sv
pipe.sv
flg_gen.sv
tst_decode.sv
flush_timer.sv
flush_ctl.sv
branch_unit.sv
tb_clk.sv
tb_check.sv
tb_top.sv

//--- tb_check.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// inputs sampled on the rising edge, outputs compared on the falling one
// flush window modelled as a plain count of FLUSH_CYC cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_check (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  logic                       valid_i,
	input  logic                       cnd_i,
	input  logic [tst_pkg::TST_W-1:0]  tst_i,
	input  logic [tst_pkg::DATA_W-1:0] a_i,
	input  logic [tst_pkg::DATA_W-1:0] b_i,
	input  logic                       taken_i,  // DUT taken_o
	input  logic                       flush_i,  // DUT flush_o
	input  int                         phase_i,  // current test
	output int                         err_cnt_o,
	output int                         chk_cnt_o
);

	import tst_pkg::*;

	logic pend_vld;   // branch seen at the last edge
	logic pend_true;  // its expected test outcome
	logic win;        // model flush window open
	int   win_cnt;    // cycles left in the window
	logic exp_taken;
	int   err_cnt = 0;
	int   chk_cnt = 0;

	// decode rule straight from the test code table
	function automatic logic ref_true(input logic cnd, input logic [TST_W-1:0] tst,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		if (!cnd)
			return 1'b1;  // unconditional
		case (tst)
			TST_Z:   return (a == '0);
			TST_NZ:  return (a != '0);
			TST_LZ:  return ($signed(a) < 0);
			TST_NLZ: return ($signed(a) >= 0);
			TST_E:   return (a == b);
			TST_NE:  return (a != b);
			TST_LS:  return ($signed(a) < $signed(b));
			TST_NLS: return ($signed(a) >= $signed(b));
			TST_LU:  return (a < b);
			TST_NLU: return (a >= b);
			default: return 1'b1;  // codes 10..15
		endcase
	endfunction

	function automatic string phase_name(input int p);
		case (p)
			0:       return "reset";
			1:       return "directed";
			2:       return "signed_unsigned";
			3:       return "uncond_undefined";
			4:       return "flush_window";
			5:       return "random";
			default: return "unknown";
		endcase
	endfunction

	// accepted only while the window is closed
	assign exp_taken = pend_vld && pend_true && !win;

	always @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pend_vld  <= 1'b0;
			pend_true <= 1'b0;
			win       <= 1'b0;
			win_cnt   <= 0;
		end else begin
			if (exp_taken) begin
				win     <= 1'b1;
				win_cnt <= FLUSH_CYC;
			end else if (win) begin
				win_cnt <= win_cnt - 1;
				if (win_cnt == 1)
					win <= 1'b0;  // last window cycle
			end
			pend_vld  <= valid_i;
			pend_true <= ref_true(cnd_i, tst_i, a_i, b_i);
		end
	end

	// mid-cycle compare, DUT outputs settled
	always @(negedge clk_i) begin
		chk_cnt = chk_cnt + 1;
		if (taken_i !== exp_taken) begin
			err_cnt = err_cnt + 1;
			$display("[FAIL] %s: taken_o expected %0b, actual %0b at %0t",
				phase_name(phase_i), exp_taken, taken_i, $time);
		end
		if (flush_i !== win) begin
			err_cnt = err_cnt + 1;
			$display("[FAIL] %s: flush_o expected %0b, actual %0b at %0t",
				phase_name(phase_i), win, flush_i, $time);
		end
	end

	assign err_cnt_o = err_cnt;
	assign chk_cnt_o = chk_cnt;

endmodule

`default_nettype wire

//--- tb_clk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// free running clock, reset low from time 0 for RST_CYC edges
// reset released on a falling edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_clk #(
	parameter int PERIOD_NS = 4,  // full clock period
	parameter int RST_CYC   = 3   // rising edges under reset
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (RST_CYC) @(posedge clk_o);
		@(negedge clk_o);  // release away from the active edge
		rst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

//--- tb_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// inputs change on the falling edge only
// run bounded by MAX_CYC, worked out from the phase lengths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_top;

	import tst_pkg::*;

	localparam int BR_CYC     = FLUSH_CYC + 4;  // one spaced branch incl. window
	localparam int N_DIRECTED = 50;             // spaced branches, phases 1..4
	localparam int N_RANDOM   = 300;
	localparam int MAX_CYC    = 3 + N_DIRECTED * BR_CYC + N_RANDOM + 2 * BR_CYC + 50;

	// operand pairs per code pair, [2p] makes the even code true
	localparam logic [DATA_W-1:0] A_DIR [10] = '{32'h0, 32'h5, 32'hFFFF_FFFF, 32'h7,
		32'h1234, 32'h1234, 32'hFFFF_FFFB, 32'h3, 32'h3, 32'h5};
	localparam logic [DATA_W-1:0] B_DIR [10] = '{32'h0, 32'h0, 32'h0, 32'h0,
		32'h1234, 32'h1235, 32'h3, 32'hFFFF_FFFB, 32'h5, 32'h3};

	logic              clk;
	logic              rst_n;
	logic              valid;
	logic              cnd;
	logic [TST_W-1:0]  tst;
	logic [DATA_W-1:0] a_op;
	logic [DATA_W-1:0] b_op;
	logic              taken;
	logic              flush;
	int                phase;
	int                err_cnt;
	int                chk_cnt;
	int                cyc = 0;
	logic [31:0]       rnd;  // generator state

	tb_clk #(.PERIOD_NS(4), .RST_CYC(3)) u_clk (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	branch_unit UUT (
		.clk_i   (clk),
		.rst_n_i (rst_n),
		.valid_i (valid),
		.cnd_i   (cnd),
		.tst_i   (tst),
		.a_i     (a_op),
		.b_i     (b_op),
		.taken_o (taken),
		.flush_o (flush)
	);

	tb_check u_chk (
		.clk_i     (clk),
		.rst_n_i   (rst_n),
		.valid_i   (valid),
		.cnd_i     (cnd),
		.tst_i     (tst),
		.a_i       (a_op),
		.b_i       (b_op),
		.taken_i   (taken),
		.flush_i   (flush),
		.phase_i   (phase),
		.err_cnt_o (err_cnt),
		.chk_cnt_o (chk_cnt)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic drive_branch(input logic v, input logic c, input logic [TST_W-1:0] t,
		input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
		@(negedge clk);
		valid = v;
		cnd   = c;
		tst   = t;
		a_op  = a;
		b_op  = b;
	endtask

	// idle until a window opened by the last branch has closed
	task automatic wait_window_end();
		drive_branch(1'b0, 1'b0, '0, '0, '0);
		@(negedge clk);  // flush_o visible from here
		while (flush)
			@(negedge clk);
	endtask

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= MAX_CYC) begin
			$display("timeout: run stopped after %0d cycles", cyc);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial begin
		valid = 1'b0;
		cnd   = 1'b0;
		tst   = '0;
		a_op  = '0;
		b_op  = '0;
		phase = 0;
		rnd   = 32'h26ff;
		@(posedge rst_n);
		@(negedge clk);  // first cycle out of reset, still quiet

		phase = 1;  // every code, true and false operands
		for (int k = 0; k < 10; k++) begin
			for (int s = 0; s < 2; s++) begin
				drive_branch(1'b1, 1'b1, TST_W'(k), A_DIR[(k / 2) * 2 + s], B_DIR[(k / 2) * 2 + s]);
				wait_window_end();
			end
		end

		phase = 2;  // a = -5, b = 3
		drive_branch(1'b1, 1'b1, TST_LS, 32'hFFFF_FFFB, 32'h3);
		wait_window_end();
		drive_branch(1'b1, 1'b1, TST_LU, 32'hFFFF_FFFB, 32'h3);
		wait_window_end();
		drive_branch(1'b1, 1'b1, TST_NLU, 32'hFFFF_FFFB, 32'h3);
		wait_window_end();

		phase = 3;
		for (int k = 0; k < 16; k++) begin
			drive_branch(1'b1, 1'b0, TST_W'(k), 32'h5, 32'h0);  // cnd 0, any code
			wait_window_end();
		end
		for (int k = 10; k < 16; k++) begin
			drive_branch(1'b1, 1'b1, TST_W'(k), 32'h5, 32'h0);  // undefined codes
			wait_window_end();
		end

		phase = 4;  // strobes through the whole window and one past it
		for (int k = 0; k < FLUSH_CYC + 2; k++)
			drive_branch(1'b1, 1'b0, TST_Z, 32'h1, 32'h0);
		wait_window_end();

		phase = 5;
		for (int k = 0; k < N_RANDOM; k++) begin
			rnd = lcg_step(rnd);
			drive_branch(1'b1, rnd[31:30] != 2'b00, rnd[27:24], lcg_step(rnd), '0);
			rnd = lcg_step(rnd);
			if (rnd[29:28] == 2'b00)
				a_op = '0;  // zero tests
			rnd = lcg_step(rnd);
			b_op = (rnd[31:30] == 2'b00) ? a_op : rnd;  // equal operands now and then
		end
		wait_window_end();

		repeat (2) @(posedge clk);
		$display("summary: %0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- tst_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flags are never registered here, only cnd/tst and result
// REGS_TST must match any delay the flags see upstream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tst_decode #(
	parameter int REGS_TST = 0,  // stages on cnd/tst
	parameter int REGS_OUT = 0   // stages on result
) (
	input  logic                      clk_i,
	input  logic                      rst_n_i,
	input  logic                      flg_nz_i,
	input  logic                      flg_lz_i,
	input  logic                      flg_ne_i,
	input  logic                      flg_lt_i,
	input  logic                      cnd_i,     // 1 = conditional
	input  logic [tst_pkg::TST_W-1:0] tst_i,
	output logic                      result_o   // 1 = test true
);

	import tst_pkg::*;

	typedef struct packed {
		logic             cnd;
		logic [TST_W-1:0] tst;
	} tst_fld_t;

	tst_fld_t fld;     // test fields after the optional regs
	logic     res;     // flag pick
	logic     result;  // before output regs

	pipe #(.DEPTH(REGS_TST), .data_t(tst_fld_t), .RESET_VAL('0)) u_tst_regs (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.data_i  ('{cnd: cnd_i, tst: tst_i}),
		.data_o  (fld)
	);

	// code picks a flag, odd/even pairs are inverses
	always_comb begin
		case (fld.tst)
			TST_Z:   res = ~flg_nz_i;
			TST_NZ:  res =  flg_nz_i;
			TST_LZ:  res =  flg_lz_i;
			TST_NLZ: res = ~flg_lz_i;
			TST_E:   res = ~flg_ne_i;
			TST_NE:  res =  flg_ne_i;
			TST_LS:  res =  flg_lt_i;  // flg_gen already did the signed compare
			TST_NLS: res = ~flg_lt_i;
			TST_LU:  res =  flg_lt_i;
			TST_NLU: res = ~flg_lt_i;
			default: res = 1'b1;       // undefined codes act as always
		endcase
	end

	assign result = fld.cnd ? res : 1'b1;  // unconditional is always true

	pipe #(.DEPTH(REGS_OUT), .data_t(logic), .RESET_VAL(1'b0)) u_out_regs (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.data_i  (result),
		.data_o  (result_o)
	);

endmodule

`default_nettype wire

//--- tst_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// test codes 10..15 are undefined and decode as true
// FLUSH_CYC must be at least 1, CNT_W follows from it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package tst_pkg;

	// widths
	localparam int DATA_W = 32;  // operand width
	localparam int TST_W  = 4;   // test field width

	// test codes
	// z/nz look at a alone, e/ne compare a with b
	localparam logic [TST_W-1:0] TST_Z   = TST_W'(0);  // a == 0
	localparam logic [TST_W-1:0] TST_NZ  = TST_W'(1);  // a != 0
	localparam logic [TST_W-1:0] TST_LZ  = TST_W'(2);  // a < 0, signed
	localparam logic [TST_W-1:0] TST_NLZ = TST_W'(3);  // a >= 0
	localparam logic [TST_W-1:0] TST_E   = TST_W'(4);  // a == b
	localparam logic [TST_W-1:0] TST_NE  = TST_W'(5);  // a != b
	localparam logic [TST_W-1:0] TST_LS  = TST_W'(6);  // a < b signed
	localparam logic [TST_W-1:0] TST_NLS = TST_W'(7);  // a >= b signed
	localparam logic [TST_W-1:0] TST_LU  = TST_W'(8);  // a < b unsigned
	localparam logic [TST_W-1:0] TST_NLU = TST_W'(9);  // a >= b unsigned

	// flush window
	localparam int FLUSH_CYC = 3;                    // cycles flush stays high
	localparam int CNT_W     = $clog2(FLUSH_CYC + 1);  // holds FLUSH_CYC itself

endpackage

`default_nettype wire
